/* logic/addr_translate.sv */
`timescale 1ns/100ps

module addr_translate (
  input  agc_pkg::addr_t     addr_pc,
  input  agc_pkg::addr_t     addr_rd,
  input  agc_pkg::addr_t     addr_wr,
  input  agc_pkg::bank_t     bits_eb,
  input  agc_pkg::bank_t     bits_fb,
  input  logic               mem_wr_req,
  output agc_pkg::rom_addr_t rom_addr_pc,
  output agc_pkg::rom_addr_t rom_addr_rd,
  output agc_pkg::ram_addr_t ram_addr_rd,
  output agc_pkg::ram_addr_t ram_addr_wr,
  output logic               ram_wr_en
);
  import agc_pkg::*;

  rom_addr_t rom_rd_map;
  ram_addr_t ram_rd_map;
  logic      rd_is_rom;
  logic      wr_is_ram;

  // Instruction fetch always from ROM
  rom_bank_map i_rom_pc (.addr_soft(addr_pc), .bits_fb(bits_fb), .addr_rom(rom_addr_pc));

  // Both translations of the read address, one is kept
  rom_bank_map i_rom_rd (.addr_soft(addr_rd), .bits_fb(bits_fb), .addr_rom(rom_rd_map));
  ram_bank_map i_ram_rd (.addr_soft(addr_rd), .bits_eb(bits_eb), .addr_ram(ram_rd_map));

  // Writes only ever land in erasable memory
  ram_bank_map i_ram_wr (.addr_soft(addr_wr), .bits_eb(bits_eb), .addr_ram(ram_addr_wr));

  assign rd_is_rom = addr_rd >= ERASABLE_LIMIT;
  assign wr_is_ram = addr_wr < ERASABLE_LIMIT;

  // Unused memory gets a parked address
  assign rom_addr_rd = rd_is_rom ? rom_rd_map : ROM_IDLE_ADDR;
  assign ram_addr_rd = rd_is_rom ? '0 : ram_rd_map;

  // Stores aimed at ROM are dropped
  assign ram_wr_en = mem_wr_req && wr_is_ram;

endmodule

/* logic/agc_core_regs.sv */
`timescale 1ns/100ps

module agc_core_regs (
  input  logic               clk,
  input  logic               rst_l,
  // Central register file
  input  logic               wr1_en,
  input  logic               wr2_en,
  input  agc_pkg::reg_t      wr1_sel,
  input  agc_pkg::reg_t      wr2_sel,
  input  agc_pkg::word_t     wr1_data,
  input  agc_pkg::word_t     wr2_data,
  input  agc_pkg::reg_t      rs1_sel,
  input  agc_pkg::reg_t      rs2_sel,
  output agc_pkg::word_t     rs1_data,
  output agc_pkg::word_t     rs2_data,
  // I/O registers
  input  logic               io_wr_en,
  input  agc_pkg::io_reg_t   io_wr_sel,
  input  agc_pkg::word_t     io_wr_data,
  input  agc_pkg::io_reg_t   io_rd_sel,
  input  agc_pkg::word_t     dsky_verb,
  input  agc_pkg::word_t     dsky_noun,
  input  agc_pkg::word_t     mission_time,
  input  agc_pkg::word_t     apogee,
  input  agc_pkg::word_t     perigee,
  output agc_pkg::word_t     io_rd_data,
  // Address translation
  input  agc_pkg::addr_t     addr_pc,
  input  agc_pkg::addr_t     addr_rd,
  input  agc_pkg::addr_t     addr_wr,
  input  logic               mem_wr_req,
  output agc_pkg::rom_addr_t rom_addr_pc,
  output agc_pkg::rom_addr_t rom_addr_rd,
  output agc_pkg::ram_addr_t ram_addr_rd,
  output agc_pkg::ram_addr_t ram_addr_wr,
  output logic               ram_wr_en
);
  import agc_pkg::*;

  // Bank bits stay inside
  bank_t bits_eb;
  bank_t bits_fb;

  central_regs i_central_regs (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr1_en   (wr1_en),
    .wr2_en   (wr2_en),
    .wr1_sel  (wr1_sel),
    .wr2_sel  (wr2_sel),
    .wr1_data (wr1_data),
    .wr2_data (wr2_data),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .bits_eb  (bits_eb),
    .bits_fb  (bits_fb)
  );

  io_channels i_io_channels (
    .clk          (clk),
    .rst_l        (rst_l),
    .io_wr_en     (io_wr_en),
    .io_wr_sel    (io_wr_sel),
    .io_wr_data   (io_wr_data),
    .io_rd_sel    (io_rd_sel),
    .dsky_verb    (dsky_verb),
    .dsky_noun    (dsky_noun),
    .mission_time (mission_time),
    .apogee       (apogee),
    .perigee      (perigee),
    .io_rd_data   (io_rd_data)
  );

  addr_translate i_addr_translate (
    .addr_pc     (addr_pc),
    .addr_rd     (addr_rd),
    .addr_wr     (addr_wr),
    .bits_eb     (bits_eb),
    .bits_fb     (bits_fb),
    .mem_wr_req  (mem_wr_req),
    .rom_addr_pc (rom_addr_pc),
    .rom_addr_rd (rom_addr_rd),
    .ram_addr_rd (ram_addr_rd),
    .ram_addr_wr (ram_addr_wr),
    .ram_wr_en   (ram_wr_en)
  );

endmodule

/* logic/agc_pkg.sv */
package agc_pkg;

  // Architectural widths
  localparam int WORD_W     = 15;
  localparam int ADDR_W     = 12;
  localparam int ROM_ADDR_W = 14;
  localparam int RAM_ADDR_W = 11;
  localparam int BANK_W     = 3;

  // One machine word, ones' complement
  typedef logic [WORD_W-1:0]     word_t;
  // Software address as seen by instructions
  typedef logic [ADDR_W-1:0]     addr_t;
  // Physical memory addresses
  typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
  // EB or FB field
  typedef logic [BANK_W-1:0]     bank_t;

  // Central register selects, codes 13 to 15 unused
  typedef enum logic [3:0] {
    A, L, Q, EB, FB, BB, ZERO, CYR, SR, CYL, SL, TIME1, TIME2
  } reg_t;

  // I/O selects
  // Codes 0 to 8 writable, 9 to 13 input words, 14 and 15 unused
  typedef enum logic [3:0] {
    DSKY_REG_1_HIGH  = 4'd0,
    DSKY_REG_1_LOW   = 4'd1,
    DSKY_REG_2_HIGH  = 4'd2,
    DSKY_REG_2_LOW   = 4'd3,
    DSKY_REG_3_HIGH  = 4'd4,
    DSKY_REG_3_LOW   = 4'd5,
    DSKY_PROG_NUM    = 4'd6,
    DSKY_LAMPS       = 4'd7,
    AXI_CALC_RES     = 4'd8,
    DSKY_VERB        = 4'd9,
    DSKY_NOUN        = 4'd10,
    AXI_MISSION_TIME = 4'd11,
    AXI_APOGEE       = 4'd12,
    AXI_PERIGEE      = 4'd13
  } io_reg_t;

  // Memory map, software side
  localparam addr_t ROM_FIXED_BASE       = 12'o4000;
  localparam addr_t ROM_BANK_SIZE        = 12'o2000;
  localparam addr_t RAM_FIXED_LIMIT      = 12'o1400;
  localparam addr_t RAM_BANK_SIZE        = 12'o0400;
  localparam addr_t RAM_HIGH_BANK_OFFSET = 12'o2000;
  // Reads at or above this go to ROM
  localparam addr_t ERASABLE_LIMIT       = 12'o2000;

  // ROM address parked on while a read targets RAM
  localparam rom_addr_t ROM_IDLE_ADDR = 14'o2000;

  // Bank field positions inside a word
  localparam int EB_LSB = 9;
  localparam int FB_LSB = 12;

  // Program number field on the display
  localparam int PROG_NUM_BITS = 5;

endpackage

/* logic/central_regs.sv */
`timescale 1ns/100ps

module central_regs (
  input  logic           clk,
  input  logic           rst_l,
  input  logic           wr1_en,
  input  logic           wr2_en,
  input  agc_pkg::reg_t  wr1_sel,
  input  agc_pkg::reg_t  wr2_sel,
  input  agc_pkg::word_t wr1_data,
  input  agc_pkg::word_t wr2_data,
  input  agc_pkg::reg_t  rs1_sel,
  input  agc_pkg::reg_t  rs2_sel,
  output agc_pkg::word_t rs1_data,
  output agc_pkg::word_t rs2_data,
  output agc_pkg::bank_t bits_eb,
  output agc_pkg::bank_t bits_fb
);
  import agc_pkg::*;

  // Stored state
  word_t reg_a, reg_l, reg_q;
  bank_t reg_eb, reg_fb;
  word_t reg_cyr, reg_sr, reg_cyl, reg_sl;
  word_t reg_time1, reg_time2;

  // State after the coming edge
  word_t nxt_a, nxt_l, nxt_q;
  bank_t nxt_eb, nxt_fb;
  word_t nxt_cyr, nxt_sr, nxt_cyl, nxt_sl;
  word_t nxt_time1, nxt_time2;

  // Per-port write and read views, index 0 is port 1
  logic  wr_en  [2];
  reg_t  wr_sel [2];
  word_t wr_fmt [2];
  reg_t  rs_sel [2];
  logic  rs_hit [2];
  word_t rs_view [2];

  // Editing registers keep a shifted copy
  function automatic word_t format_write(input reg_t sel, input word_t data);
    word_t fmt;
    case (sel)
      CYR:     fmt = {data[0], data[WORD_W-1:1]};
      // Arithmetic shift, sign kept
      SR:      fmt = {data[WORD_W-1], data[WORD_W-1:1]};
      CYL:     fmt = {data[WORD_W-2:0], data[WORD_W-1]};
      SL:      fmt = {data[WORD_W-2:0], 1'b0};
      default: fmt = data;
    endcase
    return fmt;
  endfunction

  // Word seen on a read port for a given register set
  function automatic word_t read_view(
    input reg_t  sel,
    input word_t a, l, q,
    input bank_t eb, fb,
    input word_t cyr, sr, cyl, sl,
    input word_t t1, t2
  );
    word_t view;
    view = '0;
    case (sel)
      A:     view = a;
      L:     view = l;
      Q:     view = q;
      // Bank registers show only their field
      EB:    view[EB_LSB +: BANK_W] = eb;
      FB:    view[FB_LSB +: BANK_W] = fb;
      BB: begin
        view[EB_LSB +: BANK_W] = eb;
        view[FB_LSB +: BANK_W] = fb;
      end
      CYR:   view = cyr;
      SR:    view = sr;
      CYL:   view = cyl;
      SL:    view = sl;
      TIME1: view = t1;
      TIME2: view = t2;
      // ZERO and unused codes
      default: view = '0;
    endcase
    return view;
  endfunction

  // Formatting done once per port
  always_comb begin
    wr_en[0]  = wr1_en;
    wr_en[1]  = wr2_en;
    wr_sel[0] = wr1_sel;
    wr_sel[1] = wr2_sel;
    wr_fmt[0] = format_write(wr1_sel, wr1_data);
    wr_fmt[1] = format_write(wr2_sel, wr2_data);
    rs_sel[0] = rs1_sel;
    rs_sel[1] = rs2_sel;
  end

  // Next state, port 2 applied last so it wins
  always_comb begin
    nxt_a     = reg_a;
    nxt_l     = reg_l;
    nxt_q     = reg_q;
    nxt_eb    = reg_eb;
    nxt_fb    = reg_fb;
    nxt_cyr   = reg_cyr;
    nxt_sr    = reg_sr;
    nxt_cyl   = reg_cyl;
    nxt_sl    = reg_sl;
    nxt_time1 = reg_time1;
    nxt_time2 = reg_time2;
    for (int p = 0; p < 2; p++) begin
      if (wr_en[p]) begin
        case (wr_sel[p])
          A:     nxt_a = wr_fmt[p];
          L:     nxt_l = wr_fmt[p];
          Q:     nxt_q = wr_fmt[p];
          EB:    nxt_eb = wr_fmt[p][EB_LSB +: BANK_W];
          FB:    nxt_fb = wr_fmt[p][FB_LSB +: BANK_W];
          // BB sets both fields at once
          BB: begin
            nxt_eb = wr_fmt[p][EB_LSB +: BANK_W];
            nxt_fb = wr_fmt[p][FB_LSB +: BANK_W];
          end
          CYR:   nxt_cyr = wr_fmt[p];
          SR:    nxt_sr = wr_fmt[p];
          CYL:   nxt_cyl = wr_fmt[p];
          SL:    nxt_sl = wr_fmt[p];
          TIME1: nxt_time1 = wr_fmt[p];
          TIME2: nxt_time2 = wr_fmt[p];
          default: begin
            // ZERO and unused codes drop the write
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      reg_a     <= '0;
      reg_l     <= '0;
      reg_q     <= '0;
      reg_eb    <= '0;
      reg_fb    <= '0;
      reg_cyr   <= '0;
      reg_sr    <= '0;
      reg_cyl   <= '0;
      reg_sl    <= '0;
      reg_time1 <= '0;
      reg_time2 <= '0;
    end else begin
      reg_a     <= nxt_a;
      reg_l     <= nxt_l;
      reg_q     <= nxt_q;
      reg_eb    <= nxt_eb;
      reg_fb    <= nxt_fb;
      reg_cyr   <= nxt_cyr;
      reg_sr    <= nxt_sr;
      reg_cyl   <= nxt_cyl;
      reg_sl    <= nxt_sl;
      reg_time1 <= nxt_time1;
      reg_time2 <= nxt_time2;
    end
  end

  // Read ports, forwarded from next state on a write hit
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rs_hit[p] = (wr_en[0] && (wr_sel[0] == rs_sel[p])) ||
                  (wr_en[1] && (wr_sel[1] == rs_sel[p]));
      if (rs_hit[p]) begin
        rs_view[p] = read_view(rs_sel[p], nxt_a, nxt_l, nxt_q, nxt_eb, nxt_fb,
                               nxt_cyr, nxt_sr, nxt_cyl, nxt_sl,
                               nxt_time1, nxt_time2);
      end else begin
        rs_view[p] = read_view(rs_sel[p], reg_a, reg_l, reg_q, reg_eb, reg_fb,
                               reg_cyr, reg_sr, reg_cyl, reg_sl,
                               reg_time1, reg_time2);
      end
    end
  end

  assign rs1_data = rs_view[0];
  assign rs2_data = rs_view[1];

  // Bank taps for address translation, stored state only
  assign bits_eb = reg_eb;
  assign bits_fb = reg_fb;

endmodule

/* logic/io_channels.sv */
`timescale 1ns/100ps

module io_channels (
  input  logic             clk,
  input  logic             rst_l,
  input  logic             io_wr_en,
  input  agc_pkg::io_reg_t io_wr_sel,
  input  agc_pkg::word_t   io_wr_data,
  input  agc_pkg::io_reg_t io_rd_sel,
  input  agc_pkg::word_t   dsky_verb,
  input  agc_pkg::word_t   dsky_noun,
  input  agc_pkg::word_t   mission_time,
  input  agc_pkg::word_t   apogee,
  input  agc_pkg::word_t   perigee,
  output agc_pkg::word_t   io_rd_data
);
  import agc_pkg::*;

  // Display register pairs, codes 0 to 5
  word_t                    dsky_q [6];
  logic [PROG_NUM_BITS-1:0] prog_num_q;
  word_t                    lamps_q;
  word_t                    calc_res_q;

  logic  wr_valid;
  // Write data as it will read back
  word_t wr_view;

  // Only codes 0 to 8 take writes
  assign wr_valid = io_wr_en && (io_wr_sel <= AXI_CALC_RES);

  always_comb begin
    if (io_wr_sel == DSKY_PROG_NUM) begin
      wr_view = {{(WORD_W - PROG_NUM_BITS){1'b0}}, io_wr_data[PROG_NUM_BITS-1:0]};
    end else begin
      wr_view = io_wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      for (int i = 0; i < 6; i++) begin
        dsky_q[i] <= '0;
      end
      prog_num_q <= '0;
      lamps_q    <= '0;
      calc_res_q <= '0;
    end else if (wr_valid) begin
      case (io_wr_sel)
        DSKY_REG_1_HIGH, DSKY_REG_1_LOW,
        DSKY_REG_2_HIGH, DSKY_REG_2_LOW,
        DSKY_REG_3_HIGH, DSKY_REG_3_LOW: dsky_q[io_wr_sel[2:0]] <= io_wr_data;
        // Low field only
        DSKY_PROG_NUM: prog_num_q <= io_wr_data[PROG_NUM_BITS-1:0];
        DSKY_LAMPS:    lamps_q <= io_wr_data;
        AXI_CALC_RES:  calc_res_q <= io_wr_data;
        default: begin
          // Input words are read only
        end
      endcase
    end
  end

  // Read mux with same-cycle forwarding
  always_comb begin
    if (wr_valid && (io_rd_sel == io_wr_sel)) begin
      io_rd_data = wr_view;
    end else begin
      case (io_rd_sel)
        DSKY_REG_1_HIGH, DSKY_REG_1_LOW,
        DSKY_REG_2_HIGH, DSKY_REG_2_LOW,
        DSKY_REG_3_HIGH, DSKY_REG_3_LOW: io_rd_data = dsky_q[io_rd_sel[2:0]];
        // Upper bits read zero
        DSKY_PROG_NUM:    io_rd_data = {{(WORD_W - PROG_NUM_BITS){1'b0}}, prog_num_q};
        DSKY_LAMPS:       io_rd_data = lamps_q;
        AXI_CALC_RES:     io_rd_data = calc_res_q;
        // Input words pass straight through
        DSKY_VERB:        io_rd_data = dsky_verb;
        DSKY_NOUN:        io_rd_data = dsky_noun;
        AXI_MISSION_TIME: io_rd_data = mission_time;
        AXI_APOGEE:       io_rd_data = apogee;
        AXI_PERIGEE:      io_rd_data = perigee;
        default:          io_rd_data = '0;
      endcase
    end
  end

endmodule

/* logic/ram_bank_map.sv */
`timescale 1ns/100ps

module ram_bank_map (
  input  agc_pkg::addr_t     addr_soft,
  input  agc_pkg::bank_t     bits_eb,
  output agc_pkg::ram_addr_t addr_ram
);
  import agc_pkg::*;

  logic      addr_is_fixed;
  ram_addr_t offset_pre;
  ram_addr_t offset_bank;
  ram_addr_t addr_bank;

  // Fixed erasable below octal 1400 maps one to one
  assign addr_is_fixed = addr_soft < RAM_FIXED_LIMIT;

  // Low two EB bits pick one of four banks
  always_comb begin
    case (bits_eb[1:0])
      2'd0: offset_pre = '0;
      2'd1: offset_pre = ram_addr_t'(RAM_BANK_SIZE);
      2'd2: offset_pre = ram_addr_t'(RAM_BANK_SIZE << 1);
      2'd3: offset_pre = ram_addr_t'(RAM_BANK_SIZE + (RAM_BANK_SIZE << 1));
    endcase
  end

  // EB msb selects the high bank regardless of the low bits
  assign offset_bank = bits_eb[2] ? ram_addr_t'(RAM_HIGH_BANK_OFFSET) : offset_pre;

  // Wraps at 11 bits
  assign addr_bank = addr_soft[RAM_ADDR_W-1:0] + offset_bank;

  assign addr_ram = addr_is_fixed ? addr_soft[RAM_ADDR_W-1:0] : addr_bank;

endmodule

/* logic/rom_bank_map.sv */
`timescale 1ns/100ps

module rom_bank_map (
  input  agc_pkg::addr_t     addr_soft,
  input  agc_pkg::bank_t     bits_fb,
  output agc_pkg::rom_addr_t addr_rom
);
  import agc_pkg::*;

  logic      addr_is_fixed;
  addr_t     addr_fixed;
  rom_addr_t offset_bank;
  rom_addr_t addr_bank;

  // Fixed ROM sits at the top of the software space
  assign addr_is_fixed = addr_soft >= ROM_FIXED_BASE;
  assign addr_fixed    = addr_soft - ROM_FIXED_BASE;

  // FB times bank size, table instead of multiplier
  always_comb begin
    case (bits_fb)
      3'd0: offset_bank = 14'o00000;
      3'd1: offset_bank = 14'o02000;
      3'd2: offset_bank = 14'o04000;
      3'd3: offset_bank = 14'o06000;
      3'd4: offset_bank = 14'o10000;
      3'd5: offset_bank = 14'o12000;
      3'd6: offset_bank = 14'o14000;
      3'd7: offset_bank = 14'o16000;
    endcase
  end

  // Banked window skips past fixed ROM, wraps at 14 bits
  assign addr_bank = rom_addr_t'(addr_soft) + rom_addr_t'(ROM_BANK_SIZE) + offset_bank;

  assign addr_rom = addr_is_fixed ? rom_addr_t'(addr_fixed) : addr_bank;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module agc_core_regs_tb \
  -f vlog.f --Mdir obj_dir -o sim_agc_core_regs
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_agc_core_regs
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

/* verification/agc_core_regs_tb.sv */
`timescale 1ns/100ps

module agc_core_regs_tb;
  import agc_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int SETTLE_NS   = CLK_PERIOD / 4;
  // Cycle counts per test
  localparam int RESET_CYC   = 16;
  localparam int RST_CHK_CYC = 16;
  localparam int CENTRAL_CYC = 500;
  localparam int FWD_CYC     = 200;
  localparam int ADDR_CYC    = 300;
  localparam int IO_CYC      = 300;
  localparam int BLOCK_CYC   = 200;
  localparam int TOTAL_CYC   = RESET_CYC + 1 + RST_CHK_CYC + CENTRAL_CYC + FWD_CYC +
                               ADDR_CYC + IO_CYC + BLOCK_CYC;
  localparam int TIMEOUT_NS  = 2 * TOTAL_CYC * CLK_PERIOD;

  logic      clk;
  logic      rst_l;
  logic      wr1_en, wr2_en;
  reg_t      wr1_sel, wr2_sel, rs1_sel, rs2_sel;
  word_t     wr1_data, wr2_data, rs1_data, rs2_data;
  logic      io_wr_en;
  io_reg_t   io_wr_sel, io_rd_sel;
  word_t     io_wr_data, io_rd_data;
  word_t     dsky_verb, dsky_noun, mission_time, apogee, perigee;
  addr_t     addr_pc, addr_rd, addr_wr;
  logic      mem_wr_req;
  rom_addr_t rom_addr_pc, rom_addr_rd;
  ram_addr_t ram_addr_rd, ram_addr_wr;
  logic      ram_wr_en;

  integer seed;

  // Model state, current and after the coming edge
  word_t m_reg [16];
  word_t n_reg [16];
  bank_t m_eb, m_fb;
  bank_t n_eb, n_fb;
  // I/O model, codes 0 to 8 used
  word_t io_m [16];

  agc_core_regs i_agc_core_regs (
    .clk          (clk),
    .rst_l        (rst_l),
    .wr1_en       (wr1_en),
    .wr2_en       (wr2_en),
    .wr1_sel      (wr1_sel),
    .wr2_sel      (wr2_sel),
    .wr1_data     (wr1_data),
    .wr2_data     (wr2_data),
    .rs1_sel      (rs1_sel),
    .rs2_sel      (rs2_sel),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .io_wr_en     (io_wr_en),
    .io_wr_sel    (io_wr_sel),
    .io_wr_data   (io_wr_data),
    .io_rd_sel    (io_rd_sel),
    .dsky_verb    (dsky_verb),
    .dsky_noun    (dsky_noun),
    .mission_time (mission_time),
    .apogee       (apogee),
    .perigee      (perigee),
    .io_rd_data   (io_rd_data),
    .addr_pc      (addr_pc),
    .addr_rd      (addr_rd),
    .addr_wr      (addr_wr),
    .mem_wr_req   (mem_wr_req),
    .rom_addr_pc  (rom_addr_pc),
    .rom_addr_rd  (rom_addr_rd),
    .ram_addr_rd  (ram_addr_rd),
    .ram_addr_wr  (ram_addr_wr),
    .ram_wr_en    (ram_wr_en)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("Testbench failed");
    $fatal(1, "%s", why);
  endtask

  // Watchdog, twice the planned run length
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: run still going after %0d ns", TIMEOUT_NS);
    abort_run("watchdog expired");
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("error %s: expected %05o, actual %05o", name, exp, act);
      abort_run("word mismatch");
    end
  endtask

  task automatic check_rom_addr(input string name, input rom_addr_t exp, input rom_addr_t act);
    if (act !== exp) begin
      $display("error %s: expected %05o, actual %05o", name, exp, act);
      abort_run("ROM address mismatch");
    end
  endtask

  task automatic check_ram_addr(input string name, input ram_addr_t exp, input ram_addr_t act);
    if (act !== exp) begin
      $display("error %s: expected %04o, actual %04o", name, exp, act);
      abort_run("RAM address mismatch");
    end
  endtask

  task automatic check_wr_en(input string name, input bit exp, input bit act);
    if (act !== exp) begin
      $display("error %s: expected %0b, actual %0b", name, exp, act);
      abort_run("write enable mismatch");
    end
  endtask

  // Editing registers store shifted data
  function automatic word_t stored_value(input reg_t sel, input word_t data);
    case (sel)
      CYR:     return (data >> 1) | (data << 14);
      SR:      return (data >> 1) | (data & 15'h4000);
      CYL:     return (data << 1) | (data >> 14);
      SL:      return data << 1;
      default: return data;
    endcase
  endfunction

  // Read view of the model, before or after the edge
  function automatic word_t central_view(input reg_t sel, input bit after_edge);
    word_t w;
    bank_t eb;
    bank_t fb;
    eb = after_edge ? n_eb : m_eb;
    fb = after_edge ? n_fb : m_fb;
    w  = '0;
    case (sel)
      EB:      w[11:9] = eb;
      FB:      w[14:12] = fb;
      BB:      w = {fb, eb, 9'd0};
      A, L, Q, CYR, SR, CYL, SL, TIME1, TIME2: begin
        w = after_edge ? n_reg[sel] : m_reg[sel];
      end
      default: w = '0;
    endcase
    return w;
  endfunction

  function automatic bit write_hits(input reg_t sel);
    return (wr1_en && (wr1_sel == sel)) || (wr2_en && (wr2_sel == sel));
  endfunction

  task automatic start_model_cycle();
    n_reg = m_reg;
    n_eb  = m_eb;
    n_fb  = m_fb;
  endtask

  task automatic commit_model_cycle();
    m_reg = n_reg;
    m_eb  = n_eb;
    m_fb  = n_fb;
  endtask

  // Called port 1 first, so port 2 wins
  task automatic model_write(input logic en, input reg_t sel, input word_t data);
    word_t st;
    st = stored_value(sel, data);
    if (en) begin
      case (sel)
        EB: n_eb = st[11:9];
        FB: n_fb = st[14:12];
        BB: begin
          n_eb = st[11:9];
          n_fb = st[14:12];
        end
        A, L, Q, CYR, SR, CYL, SL, TIME1, TIME2: n_reg[sel] = st;
        default: begin
          // ZERO and unused codes keep nothing
        end
      endcase
    end
  endtask

  function automatic rom_addr_t rom_expect(input addr_t a, input bank_t fb);
    logic [31:0] v;
    if (a >= 12'o4000) begin
      v = 32'(a) - 32'o4000;
    end else begin
      v = 32'(a) + 32'o2000 + 32'(fb) * 32'o2000;
    end
    return v[13:0];
  endfunction

  function automatic ram_addr_t ram_expect(input addr_t a, input bank_t eb);
    logic [31:0] off;
    logic [31:0] sum;
    if (eb[2]) begin
      off = 32'o2000;
    end else begin
      off = 32'(eb[1:0]) * 32'o400;
    end
    sum = 32'(a[10:0]) + off;
    // Fixed erasable maps straight through
    if (a < 12'o1400) begin
      sum = 32'(a[10:0]);
    end
    return sum[10:0];
  endfunction

  // Prog number keeps 5 bits
  function automatic word_t io_stored(input io_reg_t sel, input word_t data);
    return (sel == DSKY_PROG_NUM) ? (data & 15'h001f) : data;
  endfunction

  function automatic word_t io_view(input io_reg_t sel);
    case (sel)
      DSKY_REG_1_HIGH, DSKY_REG_1_LOW, DSKY_REG_2_HIGH, DSKY_REG_2_LOW,
      DSKY_REG_3_HIGH, DSKY_REG_3_LOW, DSKY_PROG_NUM, DSKY_LAMPS,
      AXI_CALC_RES:     return io_m[sel];
      DSKY_VERB:        return dsky_verb;
      DSKY_NOUN:        return dsky_noun;
      AXI_MISSION_TIME: return mission_time;
      AXI_APOGEE:       return apogee;
      AXI_PERIGEE:      return perigee;
      default:          return '0;
    endcase
  endfunction

  // Every select reads zero, no store request
  task automatic reset_check();
    for (int i = 0; i < RST_CHK_CYC; i++) begin
      @(negedge clk);
      rs1_sel   = reg_t'(4'(i));
      rs2_sel   = reg_t'(4'(15 - i));
      io_rd_sel = io_reg_t'(4'(i));
      #(SETTLE_NS);
      check_word("reset rs1", '0, rs1_data);
      check_word("reset rs2", '0, rs2_data);
      check_word("reset io", '0, io_rd_data);
      check_wr_en("reset ram_wr_en", 1'b0, ram_wr_en);
    end
  endtask

  task automatic central_cycle(input string name, input bit force_hit);
    word_t exp1;
    word_t exp2;
    @(negedge clk);
    wr1_en   = ($random(seed) & 3) != 0;
    wr2_en   = ($random(seed) & 3) != 0;
    wr1_sel  = reg_t'(4'($random(seed)));
    wr2_sel  = reg_t'(4'($random(seed)));
    wr1_data = 15'($random(seed));
    wr2_data = 15'($random(seed));
    // Extra collisions for port priority
    if (($random(seed) & 7) == 0) begin
      wr2_sel = wr1_sel;
    end
    if (force_hit) begin
      wr1_en  = 1'b1;
      rs1_sel = (($random(seed) & 1) != 0) ? wr1_sel : wr2_sel;
      rs2_sel = (($random(seed) & 1) != 0) ? wr1_sel : wr2_sel;
    end else begin
      rs1_sel = reg_t'(4'($random(seed)));
      rs2_sel = reg_t'(4'($random(seed)));
    end
    start_model_cycle();
    model_write(wr1_en, wr1_sel, wr1_data);
    model_write(wr2_en, wr2_sel, wr2_data);
    exp1 = central_view(rs1_sel, write_hits(rs1_sel));
    exp2 = central_view(rs2_sel, write_hits(rs2_sel));
    #(SETTLE_NS);
    check_word({name, " rs1"}, exp1, rs1_data);
    check_word({name, " rs2"}, exp2, rs2_data);
    commit_model_cycle();
  endtask

  // Bank bits move through port 1, addresses checked on stored banks
  task automatic addr_cycle(input string name, input bit near_boundary);
    rom_addr_t exp_rom_rd;
    ram_addr_t exp_ram_rd;
    @(negedge clk);
    wr1_en = ($random(seed) & 3) == 0;
    wr2_en = 1'b0;
    case ($random(seed) & 3)
      0:       wr1_sel = EB;
      1:       wr1_sel = FB;
      default: wr1_sel = BB;
    endcase
    wr1_data = 15'($random(seed));
    addr_pc  = 12'($random(seed));
    addr_rd  = 12'($random(seed));
    if (near_boundary && (($random(seed) & 1) != 0)) begin
      // Window 1770 to 2007 octal around the ROM edge
      addr_wr = 12'o1770 + {8'd0, 4'($random(seed))};
    end else begin
      addr_wr = 12'($random(seed));
    end
    mem_wr_req = ($random(seed) & 1) != 0;
    start_model_cycle();
    model_write(wr1_en, wr1_sel, wr1_data);
    exp_rom_rd = (addr_rd >= 12'o2000) ? rom_expect(addr_rd, m_fb) : 14'o2000;
    exp_ram_rd = (addr_rd >= 12'o2000) ? 11'd0 : ram_expect(addr_rd, m_eb);
    #(SETTLE_NS);
    check_rom_addr({name, " rom_addr_pc"}, rom_expect(addr_pc, m_fb), rom_addr_pc);
    check_rom_addr({name, " rom_addr_rd"}, exp_rom_rd, rom_addr_rd);
    check_ram_addr({name, " ram_addr_rd"}, exp_ram_rd, ram_addr_rd);
    check_ram_addr({name, " ram_addr_wr"}, ram_expect(addr_wr, m_eb), ram_addr_wr);
    check_wr_en({name, " ram_wr_en"}, mem_wr_req && (addr_wr < 12'o2000), ram_wr_en);
    commit_model_cycle();
  endtask

  task automatic io_cycle();
    word_t exp;
    logic  wr_ok;
    @(negedge clk);
    io_wr_en   = ($random(seed) & 1) != 0;
    io_wr_sel  = io_reg_t'(4'($random(seed)));
    io_wr_data = 15'($random(seed));
    // Half the reads land on the register being written
    if (($random(seed) & 1) != 0) begin
      io_rd_sel = io_wr_sel;
    end else begin
      io_rd_sel = io_reg_t'(4'($random(seed)));
    end
    dsky_verb    = 15'($random(seed));
    dsky_noun    = 15'($random(seed));
    mission_time = 15'($random(seed));
    apogee       = 15'($random(seed));
    perigee      = 15'($random(seed));
    wr_ok = io_wr_en && (io_wr_sel <= AXI_CALC_RES);
    if (wr_ok && (io_rd_sel == io_wr_sel)) begin
      exp = io_stored(io_wr_sel, io_wr_data);
    end else begin
      exp = io_view(io_rd_sel);
    end
    #(SETTLE_NS);
    check_word("io register", exp, io_rd_data);
    if (wr_ok) begin
      io_m[io_wr_sel] = io_stored(io_wr_sel, io_wr_data);
    end
  endtask

  initial begin
    seed         = 1213;
    rst_l        = 1'b0;
    wr1_en       = 1'b0;
    wr2_en       = 1'b0;
    wr1_sel      = A;
    wr2_sel      = A;
    wr1_data     = '0;
    wr2_data     = '0;
    rs1_sel      = A;
    rs2_sel      = A;
    io_wr_en     = 1'b0;
    io_wr_sel    = DSKY_REG_1_HIGH;
    io_wr_data   = '0;
    io_rd_sel    = DSKY_REG_1_HIGH;
    dsky_verb    = '0;
    dsky_noun    = '0;
    mission_time = '0;
    apogee       = '0;
    perigee      = '0;
    addr_pc      = '0;
    addr_rd      = '0;
    addr_wr      = '0;
    mem_wr_req   = 1'b0;
    for (int i = 0; i < 16; i++) begin
      m_reg[i] = '0;
      io_m[i]  = '0;
    end
    m_eb = '0;
    m_fb = '0;
    repeat (RESET_CYC) @(posedge clk);
    @(negedge clk);
    rst_l = 1'b1;
    reset_check();
    repeat (CENTRAL_CYC) central_cycle("central write", 1'b0);
    repeat (FWD_CYC) central_cycle("forwarding", 1'b1);
    repeat (ADDR_CYC) addr_cycle("address translation", 1'b0);
    repeat (IO_CYC) io_cycle();
    repeat (BLOCK_CYC) addr_cycle("rom write blocking", 1'b1);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* vlog.f */
logic/agc_pkg.sv
logic/rom_bank_map.sv
logic/ram_bank_map.sv
logic/addr_translate.sv
logic/central_regs.sv
logic/io_channels.sv
logic/agc_core_regs.sv
verification/agc_core_regs_tb.sv
